//--- compile.f
rtl/icb_pkg.sv
rtl/icb_cmd_router.sv
rtl/icb_outs_fifo.sv
rtl/icb_rsp_router.sv
rtl/icb_1to6_bus.sv
verification/tb_clk_gen.sv
verification/tb_icb_1to6_bus.sv

//--- rtl/icb_1to6_bus.sv
`timescale 1ns/1ns

module icb_1to6_bus #(
  parameter int AW         = icb_pkg::ICB_AW_DEF,
  parameter int DW         = icb_pkg::ICB_DW_DEF,
  parameter int OUTS_DEPTH = 4,
  parameter int REGION_LSB = 12,
  parameter logic [icb_pkg::NUM_REGION-1:0][AW-1:0] REGION_BASE = {
    AW'(32'h0000_5000),
    AW'(32'h0000_4000),
    AW'(32'h0000_3000),
    AW'(32'h0000_2000),
    AW'(32'h0000_1000)
  }
) (
  input  logic                                  i_clk,
  input  logic                                  i_rst_n,

  // initiator side
  input  logic                                  i_cmd_valid,
  output logic                                  o_cmd_ready,
  input  logic [AW-1:0]                         i_cmd_addr,
  input  logic                                  i_cmd_read,
  input  logic [DW-1:0]                         i_cmd_wdata,
  input  logic [DW/8-1:0]                       i_cmd_wmask,

  output logic                                  o_rsp_valid,
  input  logic                                  i_rsp_ready,
  output logic [DW-1:0]                         o_rsp_rdata,
  output logic                                  o_rsp_err,

  input  logic [icb_pkg::NUM_REGION-1:0]        i_region_en,

  // target side with a broadcast payload
  output logic [icb_pkg::NUM_TGT-1:0]           o_tgt_cmd_valid,
  input  logic [icb_pkg::NUM_TGT-1:0]           i_tgt_cmd_ready,
  output logic [AW-1:0]                         o_tgt_cmd_addr,
  output logic                                  o_tgt_cmd_read,
  output logic [DW-1:0]                         o_tgt_cmd_wdata,
  output logic [DW/8-1:0]                       o_tgt_cmd_wmask,

  input  logic [icb_pkg::NUM_TGT-1:0]           i_tgt_rsp_valid,
  output logic [icb_pkg::NUM_TGT-1:0]           o_tgt_rsp_ready,
  input  logic [icb_pkg::NUM_TGT-1:0][DW-1:0]   i_tgt_rsp_rdata,
  input  logic [icb_pkg::NUM_TGT-1:0]           i_tgt_rsp_err
);

  import icb_pkg::*;

  logic push_valid;
  tgt_e push_tgt;
  logic fifo_full;
  logic head_valid;
  tgt_e head_tgt;
  logic pop;

  icb_cmd_router #(
    .AW          (AW),
    .DW          (DW),
    .REGION_LSB  (REGION_LSB),
    .REGION_BASE (REGION_BASE)
  ) u_cmd_router (
    .i_cmd_valid     (i_cmd_valid),
    .o_cmd_ready     (o_cmd_ready),
    .i_cmd_addr      (i_cmd_addr),
    .i_cmd_read      (i_cmd_read),
    .i_cmd_wdata     (i_cmd_wdata),
    .i_cmd_wmask     (i_cmd_wmask),
    .i_region_en     (i_region_en),
    .o_tgt_cmd_valid (o_tgt_cmd_valid),
    .i_tgt_cmd_ready (i_tgt_cmd_ready),
    .o_tgt_cmd_addr  (o_tgt_cmd_addr),
    .o_tgt_cmd_read  (o_tgt_cmd_read),
    .o_tgt_cmd_wdata (o_tgt_cmd_wdata),
    .o_tgt_cmd_wmask (o_tgt_cmd_wmask),
    .i_fifo_full     (fifo_full),
    .o_push_valid    (push_valid),
    .o_push_tgt      (push_tgt)
  );

  // keeps responses in command order
  icb_outs_fifo #(
    .DEPTH (OUTS_DEPTH)
  ) u_outs_fifo (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_push       (push_valid),
    .i_push_tgt   (push_tgt),
    .o_full       (fifo_full),
    .i_pop        (pop),
    .o_head_valid (head_valid),
    .o_head_tgt   (head_tgt)
  );

  icb_rsp_router #(
    .DW (DW)
  ) u_rsp_router (
    .i_head_valid    (head_valid),
    .i_head_tgt      (head_tgt),
    .o_pop           (pop),
    .i_tgt_rsp_valid (i_tgt_rsp_valid),
    .o_tgt_rsp_ready (o_tgt_rsp_ready),
    .i_tgt_rsp_rdata (i_tgt_rsp_rdata),
    .i_tgt_rsp_err   (i_tgt_rsp_err),
    .o_rsp_valid     (o_rsp_valid),
    .i_rsp_ready     (i_rsp_ready),
    .o_rsp_rdata     (o_rsp_rdata),
    .o_rsp_err       (o_rsp_err)
  );

endmodule

//--- rtl/icb_cmd_router.sv
`timescale 1ns/1ns

module icb_cmd_router #(
  parameter int AW         = icb_pkg::ICB_AW_DEF,
  parameter int DW         = icb_pkg::ICB_DW_DEF,
  parameter int REGION_LSB = 12,
  parameter logic [icb_pkg::NUM_REGION-1:0][AW-1:0] REGION_BASE = {
    AW'(32'h0000_5000),
    AW'(32'h0000_4000),
    AW'(32'h0000_3000),
    AW'(32'h0000_2000),
    AW'(32'h0000_1000)
  }
) (
  input  logic                           i_cmd_valid,
  output logic                           o_cmd_ready,
  input  logic [AW-1:0]                  i_cmd_addr,
  input  logic                           i_cmd_read,
  input  logic [DW-1:0]                  i_cmd_wdata,
  input  logic [DW/8-1:0]                i_cmd_wmask,

  input  logic [icb_pkg::NUM_REGION-1:0] i_region_en,

  output logic [icb_pkg::NUM_TGT-1:0]    o_tgt_cmd_valid,
  input  logic [icb_pkg::NUM_TGT-1:0]    i_tgt_cmd_ready,
  output logic [AW-1:0]                  o_tgt_cmd_addr,
  output logic                           o_tgt_cmd_read,
  output logic [DW-1:0]                  o_tgt_cmd_wdata,
  output logic [DW/8-1:0]                o_tgt_cmd_wmask,

  input  logic                           i_fifo_full,
  output logic                           o_push_valid,
  output icb_pkg::tgt_e                  o_push_tgt
);

  import icb_pkg::*;

  logic [NUM_REGION-1:0] region_hit;
  tgt_e                  sel_tgt;
  icb_op_e               cmd_op;
  logic                  dispatch_en;

  // compare upper address bits against each enabled base
  always_comb begin
    for (int r = 0; r < NUM_REGION; r++) begin
      region_hit[r] = i_region_en[r] &
                      (i_cmd_addr[AW-1:REGION_LSB] == REGION_BASE[r][AW-1:REGION_LSB]);
    end
  end

  // lowest matching region wins, otherwise default target
  always_comb begin
    sel_tgt = TGT_DEFAULT;
    for (int r = NUM_REGION - 1; r >= 0; r--) begin
      if (region_hit[r]) begin
        sel_tgt = tgt_e'(TGT_IDX_W'(r));
      end
    end
  end

  // no dispatch while the outstanding FIFO has no room
  assign dispatch_en = i_cmd_valid & ~i_fifo_full;

  always_comb begin
    for (int t = 0; t < NUM_TGT; t++) begin
      o_tgt_cmd_valid[t] = dispatch_en & (int'(sel_tgt) == t);
    end
  end

  assign o_cmd_ready = i_tgt_cmd_ready[sel_tgt] & ~i_fifo_full;

  // shared payload for all targets
  assign cmd_op          = icb_op_e'(i_cmd_read);
  assign o_tgt_cmd_addr  = i_cmd_addr;
  assign o_tgt_cmd_read  = (cmd_op == OP_READ);
  assign o_tgt_cmd_wdata = i_cmd_wdata;
  assign o_tgt_cmd_wmask = i_cmd_wmask;

  // record the target of every accepted command
  assign o_push_valid = i_cmd_valid & o_cmd_ready;
  assign o_push_tgt   = sel_tgt;

endmodule

//--- rtl/icb_outs_fifo.sv
`timescale 1ns/1ns

module icb_outs_fifo #(
  parameter int DEPTH = 4
) (
  input  logic          i_clk,
  input  logic          i_rst_n,

  input  logic          i_push,
  input  icb_pkg::tgt_e i_push_tgt,
  output logic          o_full,

  input  logic          i_pop,
  output logic          o_head_valid,
  output icb_pkg::tgt_e o_head_tgt
);

  import icb_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  tgt_e             mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign o_full       = (count == CNT_W'(DEPTH));
  assign o_head_valid = (count != '0);
  assign o_head_tgt   = mem[rd_ptr];

  assign do_push = i_push & ~o_full;
  assign do_pop  = i_pop & o_head_valid;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // push and pop together leave the count unchanged
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_push_tgt;
    end
  end

endmodule

//--- rtl/icb_pkg.sv
package icb_pkg;

  // default bus widths
  localparam int ICB_AW_DEF = 32;
  localparam int ICB_DW_DEF = 32;

  // five decoded regions plus one default target
  localparam int NUM_REGION = 5;
  localparam int NUM_TGT    = NUM_REGION + 1;
  localparam int TGT_IDX_W  = 3;

  // target number that the outstanding FIFO also stores
  typedef enum logic [TGT_IDX_W-1:0] {
    TGT_R0      = 3'd0,
    TGT_R1      = 3'd1,
    TGT_R2      = 3'd2,
    TGT_R3      = 3'd3,
    TGT_R4      = 3'd4,
    TGT_DEFAULT = 3'd5
  } tgt_e;

  // command direction as seen on the read flag
  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } icb_op_e;

endpackage

//--- rtl/icb_rsp_router.sv
`timescale 1ns/1ns

module icb_rsp_router #(
  parameter int DW = icb_pkg::ICB_DW_DEF
) (
  input  logic                                  i_head_valid,
  input  icb_pkg::tgt_e                         i_head_tgt,
  output logic                                  o_pop,

  input  logic [icb_pkg::NUM_TGT-1:0]           i_tgt_rsp_valid,
  output logic [icb_pkg::NUM_TGT-1:0]           o_tgt_rsp_ready,
  input  logic [icb_pkg::NUM_TGT-1:0][DW-1:0]   i_tgt_rsp_rdata,
  input  logic [icb_pkg::NUM_TGT-1:0]           i_tgt_rsp_err,

  output logic                                  o_rsp_valid,
  input  logic                                  i_rsp_ready,
  output logic [DW-1:0]                         o_rsp_rdata,
  output logic                                  o_rsp_err
);

  import icb_pkg::*;

  logic head_rsp_valid;

  // only the oldest outstanding target may answer
  assign head_rsp_valid = i_tgt_rsp_valid[i_head_tgt];

  assign o_rsp_valid = i_head_valid & head_rsp_valid;
  assign o_rsp_rdata = i_tgt_rsp_rdata[i_head_tgt];
  assign o_rsp_err   = i_tgt_rsp_err[i_head_tgt];

  // other targets see ready low and hold their response
  always_comb begin
    for (int t = 0; t < NUM_TGT; t++) begin
      o_tgt_rsp_ready[t] = i_head_valid & i_rsp_ready & (int'(i_head_tgt) == t);
    end
  end

  assign o_pop = o_rsp_valid & i_rsp_ready;

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_icb_1to6_bus \
  -f compile.f

sim_out="$(./obj_dir/Vtb_icb_1to6_bus)"
echo "$sim_out"

# a failed search makes the script exit non-zero
echo "$sim_out" | grep -q 'All tests passed!'

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 3,
  parameter int DRIVE_DLY  = 2
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // release reset a drive delay after the edge
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    #(DRIVE_DLY);
    o_rst_n = 1'b1;
  end

endmodule

//--- verification/tb_icb_1to6_bus.sv
`timescale 1ns/1ns

module tb_icb_1to6_bus;

  import icb_pkg::*;

  localparam int DRIVE_DLY    = 2;
  localparam int OUTS_DEPTH   = 4;
  localparam int REGION_LSB   = 12;
  localparam int NUM_CMDS     = 101;
  localparam int WATCHDOG_CYC = NUM_CMDS * 20 + 200;
  localparam logic [NUM_REGION-1:0][31:0] BASES = {
    32'h0000_5000, 32'h0000_4000, 32'h0000_3000, 32'h0000_2000, 32'h0000_1000
  };

  logic                           clk;
  logic                           rst_n;
  logic                           cmd_valid;
  logic                           cmd_ready;
  logic [31:0]                    cmd_addr;
  logic                           cmd_read;
  logic [31:0]                    cmd_wdata;
  logic [3:0]                     cmd_wmask;
  logic                           rsp_valid;
  logic                           rsp_ready;
  logic [31:0]                    rsp_rdata;
  logic                           rsp_err;
  logic [NUM_REGION-1:0]          region_en;
  logic [NUM_TGT-1:0]             tgt_cmd_valid;
  logic [NUM_TGT-1:0]             tgt_cmd_ready;
  logic [31:0]                    tgt_cmd_addr;
  logic                           tgt_cmd_read;
  logic [31:0]                    tgt_cmd_wdata;
  logic [3:0]                     tgt_cmd_wmask;
  logic [NUM_TGT-1:0]             tgt_rsp_valid;
  logic [NUM_TGT-1:0]             tgt_rsp_ready;
  logic [NUM_TGT-1:0][31:0]       tgt_rsp_rdata;
  logic [NUM_TGT-1:0]             tgt_rsp_err;

  int unsigned cyc = 0;
  int          tgt_hs = 0;
  int          rsp_mode;
  int          errors;
  int          err_start;
  int          ntests;
  int          nfailed;
  string       cur_test;
  logic [31:0] exp_rdata [$];
  logic        exp_err [$];

  tb_clk_gen #(
    .PERIOD     (20),
    .RST_CYCLES (3),
    .DRIVE_DLY  (DRIVE_DLY)
  ) u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  icb_1to6_bus #(
    .AW          (32),
    .DW          (32),
    .OUTS_DEPTH  (OUTS_DEPTH),
    .REGION_LSB  (REGION_LSB),
    .REGION_BASE (BASES)
  ) DUT (
    .i_clk           (clk),
    .i_rst_n         (rst_n),
    .i_cmd_valid     (cmd_valid),
    .o_cmd_ready     (cmd_ready),
    .i_cmd_addr      (cmd_addr),
    .i_cmd_read      (cmd_read),
    .i_cmd_wdata     (cmd_wdata),
    .i_cmd_wmask     (cmd_wmask),
    .o_rsp_valid     (rsp_valid),
    .i_rsp_ready     (rsp_ready),
    .o_rsp_rdata     (rsp_rdata),
    .o_rsp_err       (rsp_err),
    .i_region_en     (region_en),
    .o_tgt_cmd_valid (tgt_cmd_valid),
    .i_tgt_cmd_ready (tgt_cmd_ready),
    .o_tgt_cmd_addr  (tgt_cmd_addr),
    .o_tgt_cmd_read  (tgt_cmd_read),
    .o_tgt_cmd_wdata (tgt_cmd_wdata),
    .o_tgt_cmd_wmask (tgt_cmd_wmask),
    .i_tgt_rsp_valid (tgt_rsp_valid),
    .o_tgt_rsp_ready (tgt_rsp_ready),
    .i_tgt_rsp_rdata (tgt_rsp_rdata),
    .i_tgt_rsp_err   (tgt_rsp_err)
  );

  always @(posedge clk) cyc <= cyc + 1;

  // count target side handshakes mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      tgt_hs <= tgt_hs + $countones(tgt_cmd_valid & tgt_cmd_ready);
    end
  end

  // target models with random ready and in-order responses after 1 to 6 cycles
  for (genvar t = 0; t < NUM_TGT; t++) begin : g_tgt
    logic        tready;
    logic        tvalid;
    logic [31:0] trdata;
    logic        terr;
    logic [31:0] q_addr [$];
    logic        q_read [$];
    int unsigned q_due [$];

    assign tgt_cmd_ready[t] = tready;
    assign tgt_rsp_valid[t] = tvalid;
    assign tgt_rsp_rdata[t] = trdata;
    assign tgt_rsp_err[t]   = terr;

    initial begin
      logic        cmd_hs;
      logic        rsp_hs;
      logic [31:0] a;
      logic        rd;
      tready = 1'b0;
      tvalid = 1'b0;
      trdata = '0;
      terr   = 1'b0;
      @(posedge rst_n);
      forever begin
        @(negedge clk);
        cmd_hs = tgt_cmd_valid[t] & tready;
        rsp_hs = tvalid & tgt_rsp_ready[t];
        a      = tgt_cmd_addr;
        rd     = tgt_cmd_read;
        @(posedge clk);
        #(DRIVE_DLY);
        if (cmd_hs) begin
          q_addr.push_back(a);
          q_read.push_back(rd);
          q_due.push_back(cyc + 1 + ($urandom % 6));
        end
        if (rsp_hs) begin
          tvalid = 1'b0;
        end
        if (!tvalid && q_addr.size() > 0 && cyc >= q_due[0]) begin
          a = q_addr.pop_front();
          rd = q_read.pop_front();
          void'(q_due.pop_front());
          tvalid = 1'b1;
          trdata = a ^ (t * 32'h0101_0101);
          terr   = rd ? 1'b0 : a[2];
        end
        tready = ($urandom % 4) != 0;
      end
    end
  end

  // rsp_mode 0 keeps ready high, 1 toggles it in random spans, 2 holds it low
  initial begin
    int span;
    rsp_ready = 1'b0;
    span = 0;
    @(posedge rst_n);
    forever begin
      case (rsp_mode)
        0: rsp_ready = 1'b1;
        2: rsp_ready = 1'b0;
        default: begin
          if (span == 0) begin
            rsp_ready = ~rsp_ready;
            span = rsp_ready ? 1 + int'($urandom % 3) : 1 + int'($urandom % 8);
          end else begin
            span = span - 1;
          end
        end
      endcase
      @(posedge clk);
      #(DRIVE_DLY);
    end
  end

  // first enabled region whose base matches the upper address bits
  function automatic tgt_e exp_tgt(input logic [31:0] addr,
                                   input logic [NUM_REGION-1:0] en);
    for (int r = 0; r < NUM_REGION; r++) begin
      if (en[3'(r)] && (addr >> REGION_LSB) == (BASES[3'(r)] >> REGION_LSB)) begin
        return tgt_e'(3'(r));
      end
    end
    return TGT_DEFAULT;
  endfunction

  function automatic logic [31:0] rand_addr();
    int k;
    k = int'($urandom % 7);
    if (k < NUM_REGION) begin
      return BASES[3'(k)] | ($urandom & 32'h0000_0fff);
    end
    // bit 16 set keeps it clear of every base
    return 32'h0001_0000 | ($urandom & 32'hfffe_0fff);
  endfunction

  // compare every initiator response against the expected queue
  initial begin
    logic [31:0] er;
    logic        ee;
    forever begin
      @(negedge clk);
      if (rst_n && rsp_valid && rsp_ready) begin
        assert (exp_rdata.size() != 0) else begin
          $display("%s: response arrived with no command outstanding", cur_test);
          errors++;
        end
        if (exp_rdata.size() != 0) begin
          er = exp_rdata.pop_front();
          ee = exp_err.pop_front();
          assert (rsp_rdata == er) else begin
            $display("FAILED %s: rdata expected %08h actual %08h", cur_test, er, rsp_rdata);
            errors++;
          end
          assert (rsp_err == ee) else begin
            $display("FAILED %s: err expected %0b actual %0b", cur_test, ee, rsp_err);
            errors++;
          end
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("watchdog: the run did not complete within %0d cycles", WATCHDOG_CYC);
    $display("Test failures found");
    $finish;
  end

  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  task automatic start_cmd(input logic [31:0] addr, input icb_op_e op);
    cmd_valid = 1'b1;
    cmd_addr  = addr;
    cmd_read  = (op == OP_READ);
    cmd_wdata = $urandom;
    cmd_wmask = 4'($urandom);
  endtask

  // wait for the handshake, then record what the initiator should get back
  task automatic finish_cmd();
    tgt_e tg;
    logic done;
    tg = exp_tgt(cmd_addr, region_en);
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (cmd_ready) begin
        assert (tgt_cmd_valid == (NUM_TGT'(1) << tg)) else begin
          $display("FAILED %s: target valid expected %b actual %b",
                   cur_test, NUM_TGT'(1) << tg, tgt_cmd_valid);
          errors++;
        end
        assert ({tgt_cmd_addr, tgt_cmd_read, tgt_cmd_wdata, tgt_cmd_wmask} ==
                {cmd_addr, cmd_read, cmd_wdata, cmd_wmask}) else begin
          $display("FAILED %s: payload expected %h actual %h", cur_test,
                   {cmd_addr, cmd_read, cmd_wdata, cmd_wmask},
                   {tgt_cmd_addr, tgt_cmd_read, tgt_cmd_wdata, tgt_cmd_wmask});
          errors++;
        end
        exp_rdata.push_back(cmd_addr ^ (32'(tg) * 32'h0101_0101));
        exp_err.push_back((icb_op_e'(cmd_read) == OP_WRITE) ? cmd_addr[2] : 1'b0);
        done = 1'b1;
      end
      next_cycle();
    end
    cmd_valid = 1'b0;
  endtask

  task automatic send_cmd(input logic [31:0] addr, input icb_op_e op);
    start_cmd(addr, op);
    finish_cmd();
  endtask

  task automatic drain();
    while (exp_rdata.size() != 0) next_cycle();
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    err_start = errors;
    ntests++;
  endtask

  task automatic end_test();
    if (errors == err_start) begin
      $display("test %s: pass", cur_test);
    end else begin
      nfailed++;
      $display("test %s: %0d errors", cur_test, errors - err_start);
    end
  endtask

  initial begin
    icb_op_e op;
    void'($urandom(32'h460));
    cmd_valid = 1'b0;
    cmd_addr  = '0;
    cmd_read  = 1'b0;
    cmd_wdata = '0;
    cmd_wmask = '0;
    region_en = '1;
    rsp_mode  = 0;
    errors    = 0;
    ntests    = 0;
    nfailed   = 0;
    @(posedge rst_n);

    begin_test("idle_after_reset");
    repeat (10) begin
      @(negedge clk);
      assert (!rsp_valid && tgt_cmd_valid == '0 && tgt_rsp_ready == '0) else begin
        $display("%s: a valid or ready output is high with no command sent", cur_test);
        errors++;
      end
      next_cycle();
    end
    end_test();

    begin_test("decode_all_regions");
    send_cmd(32'h0000_1004, OP_WRITE);
    send_cmd(32'h0000_2008, OP_READ);
    send_cmd(32'h0000_300c, OP_WRITE);
    send_cmd(32'h0000_4010, OP_READ);
    send_cmd(32'h0000_5014, OP_WRITE);
    send_cmd(32'h8000_0004, OP_WRITE);
    drain();
    end_test();

    // regions 1 and 3 switched off
    begin_test("disabled_regions");
    region_en = 5'b10101;
    for (int r = 0; r < NUM_REGION; r++) begin
      send_cmd(BASES[3'(r)] | 32'h0000_0104, OP_WRITE);
      send_cmd(BASES[3'(r)] | 32'h0000_0230, OP_READ);
    end
    drain();
    region_en = '1;
    end_test();

    begin_test("back_to_back");
    repeat (40) begin
      op = (($urandom % 2) == 0) ? OP_WRITE : OP_READ;
      send_cmd(rand_addr(), op);
    end
    drain();
    end_test();

    begin_test("rsp_backpressure");
    rsp_mode = 1;
    repeat (40) begin
      op = (($urandom % 2) == 0) ? OP_WRITE : OP_READ;
      send_cmd(rand_addr(), op);
    end
    drain();
    rsp_mode = 0;
    end_test();

    begin_test("outstanding_limit");
    rsp_mode = 2;
    next_cycle();
    begin
      int hs_base;
      hs_base = tgt_hs;
      for (int i = 0; i < OUTS_DEPTH; i++) begin
        send_cmd(BASES[3'(i)] | 32'h0000_0040, OP_READ);
      end
      start_cmd(BASES[3'(4)] | 32'h0000_0044, OP_WRITE);
      repeat (8) begin
        @(negedge clk);
        assert (tgt_cmd_valid == '0 && !cmd_ready) else begin
          $display("%s: a command was dispatched with the FIFO full", cur_test);
          errors++;
        end
        next_cycle();
      end
      assert (tgt_hs - hs_base == OUTS_DEPTH) else begin
        $display("FAILED %s: handshakes expected %0d actual %0d",
                 cur_test, OUTS_DEPTH, tgt_hs - hs_base);
        errors++;
      end
    end
    rsp_mode = 0;
    finish_cmd();
    drain();
    end_test();

    $display("tests run: %0d, tests failed: %0d, errors: %0d", ntests, nfailed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
